/* design/rab_cfg_params.svh */
/*
 Sizes and address map of the RAB configuration port.
 Included by the package and by every module that sizes a port or decodes an address.
*/
`ifndef RAB_CFG_PARAMS_SVH
`define RAB_CFG_PARAMS_SVH

// AXI4-Lite port
`define RAB_AXI_DATA_WIDTH 64
`define RAB_AXI_ADDR_WIDTH 32

// L1 slice bank, four words per slice
`define RAB_N_REGS 16
`define RAB_ADDR_WIDTH_VIRT 32
`define RAB_ADDR_WIDTH_PHYS 40
`define RAB_N_FLAGS 4

// Miss handling
`define RAB_MISS_ID_WIDTH 10
`define RAB_MISS_FIFO_DEPTH 16 // Power of two

// Address map
`define RAB_L1_MAP_SIZE 32'h0000_4000 // Writes at or above are dropped
`define RAB_FIFO_ADDR_OFFS 0
`define RAB_FIFO_ID_OFFS 8

// Byte offset bits of a 64-bit word and width of the FIFO offset field
`define RAB_WORD_LSB ($clog2(`RAB_AXI_DATA_WIDTH/8))
`define RAB_FIFO_OFFS_WIDTH (`RAB_WORD_LSB + $clog2(`RAB_N_REGS) - 1)

`endif

/* design/rab_cfg_pkg.sv */
/*
 Types shared by the RAB configuration port.
 Modules name these types by scope in their headers and import the package in their bodies.
*/
`include "rab_cfg_params.svh"

package rab_cfg_pkg;

  // AXI4-Lite channel payloads
  typedef logic [`RAB_AXI_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [`RAB_AXI_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [`RAB_AXI_DATA_WIDTH/8-1:0] axi_strb_t;

  // Index of a 64-bit configuration word
  typedef logic [$clog2(`RAB_N_REGS)-1:0] reg_idx_t;

  // Miss record fields
  typedef logic [`RAB_ADDR_WIDTH_VIRT-1:0] virt_addr_t;
  typedef logic [`RAB_MISS_ID_WIDTH-1:0]   miss_id_t;

  // Per-channel progress of one AXI transfer
  typedef enum logic [1:0] {
    IDLE, // Accepting address and data
    BUSY, // Request held, one cycle of work
    RESP  // Response valid, waiting for ready
  } chan_state_e;

endpackage

/* design/axi_lite_slave.sv */
/*
 AXI4-Lite slave handshake engine.
 Turns AW/W into a one-cycle write pulse with held address, data and strobe,
 and AR into a held read address with the R response built from rd_data_i.
*/
`timescale 1ns/1ns

module axi_lite_slave (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,

  input  rab_cfg_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  rab_cfg_pkg::axi_data_t s_axi_wdata_i,
  input  rab_cfg_pkg::axi_strb_t s_axi_wstrb_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  input  rab_cfg_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output rab_cfg_pkg::axi_data_t s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,

  output logic                  wr_en_o,
  output rab_cfg_pkg::axi_addr_t wr_addr_o,
  output rab_cfg_pkg::axi_data_t wr_data_o,
  output rab_cfg_pkg::axi_strb_t wr_strb_o,
  output logic                  rd_active_o,
  output rab_cfg_pkg::axi_addr_t rd_addr_o,
  output logic                  rd_done_o,
  input  rab_cfg_pkg::axi_data_t rd_data_i
);
  import rab_cfg_pkg::*;

  chan_state_e wr_state_q;
  chan_state_e rd_state_q;

  logic aw_done_q; // Address half of the write held
  logic w_done_q;  // Data half of the write held
  logic awready_q;
  logic wready_q;
  logic bvalid_q;
  logic arready_q;
  logic rvalid_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  axi_addr_t awaddr_q;
  axi_data_t wdata_q;
  axi_strb_t wstrb_q;
  axi_addr_t araddr_q;

  assign aw_hs = s_axi_awvalid_i & awready_q;
  assign w_hs  = s_axi_wvalid_i & wready_q;
  assign b_hs  = bvalid_q & s_axi_bready_i;
  assign ar_hs = s_axi_arvalid_i & arready_q;
  assign r_hs  = rvalid_q & s_axi_rready_i;

  // Write side, AW and W may arrive in either order
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_state_q <= IDLE;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      awready_q  <= 1'b1;
      wready_q   <= 1'b1;
      bvalid_q   <= 1'b0;
    end
    else
    begin
      case (wr_state_q)
        IDLE:
        begin
          if (aw_hs)
          begin
            aw_done_q <= 1'b1;
            awready_q <= 1'b0;
          end
          else if (!aw_done_q)
            awready_q <= 1'b1; // Re-arm one cycle after B
          if (w_hs)
          begin
            w_done_q <= 1'b1;
            wready_q <= 1'b0;
          end
          else if (!w_done_q)
            wready_q <= 1'b1;
          if ((aw_done_q | aw_hs) & (w_done_q | w_hs))
            wr_state_q <= BUSY;
        end
        BUSY:
        begin
          bvalid_q   <= 1'b1; // Same edge as the register update
          wr_state_q <= RESP;
        end
        RESP:
        begin
          if (b_hs)
          begin
            bvalid_q   <= 1'b0;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
            wr_state_q <= IDLE;
          end
        end
        default: wr_state_q <= IDLE;
      endcase
    end
  end

  // Read side
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rd_state_q <= IDLE;
      arready_q  <= 1'b1;
      rvalid_q   <= 1'b0;
    end
    else
    begin
      case (rd_state_q)
        IDLE:
        begin
          if (ar_hs)
          begin
            arready_q  <= 1'b0;
            rd_state_q <= BUSY;
          end
          else
            arready_q <= 1'b1;
        end
        BUSY:
        begin
          rvalid_q   <= 1'b1; // Register lookup done from the held address
          rd_state_q <= RESP;
        end
        RESP:
        begin
          if (r_hs)
          begin
            rvalid_q   <= 1'b0;
            rd_state_q <= IDLE;
          end
        end
        default: rd_state_q <= IDLE;
      endcase
    end
  end

  // Channel payloads
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      awaddr_q <= s_axi_awaddr_i;
    if (w_hs)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
    if (ar_hs)
      araddr_q <= s_axi_araddr_i;
  end

  assign s_axi_awready_o = awready_q;
  assign s_axi_wready_o  = wready_q;
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_bresp_o   = 2'b00; // OKAY
  assign s_axi_arready_o = arready_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rresp_o   = 2'b00;
  assign s_axi_rdata_o   = rd_data_i;

  assign wr_en_o     = (wr_state_q == BUSY);
  assign wr_addr_o   = awaddr_q;
  assign wr_data_o   = wdata_q;
  assign wr_strb_o   = wstrb_q;
  assign rd_active_o = rvalid_q;
  assign rd_addr_o   = araddr_q;
  assign rd_done_o   = r_hs; // FIFO pop on this edge

endmodule

/* design/l1_cfg_regs.sv */
/*
 Bank of L1 slice configuration words, driven in parallel to the translation logic.
 Writes are byte strobed and masked to the field of each word; reads are combinational.
*/
`timescale 1ns/1ns
`include "rab_cfg_params.svh"

module l1_cfg_regs (
  input  logic                                     Clk_CI,
  input  logic                                     Rst_RBI,
  input  logic                                     wr_en_i,
  input  rab_cfg_pkg::axi_addr_t                   wr_addr_i,
  input  rab_cfg_pkg::axi_data_t                   wr_data_i,
  input  rab_cfg_pkg::axi_strb_t                   wr_strb_i,
  input  rab_cfg_pkg::axi_addr_t                   rd_addr_i,
  output rab_cfg_pkg::axi_data_t                   rd_data_o,
  output rab_cfg_pkg::axi_data_t [`RAB_N_REGS-1:0] l1_cfg_o
);
  import rab_cfg_pkg::*;

  localparam int unsigned DW = `RAB_AXI_DATA_WIDTH;

  reg_idx_t  wr_idx;
  reg_idx_t  rd_idx;
  logic      wr_hit;
  axi_data_t strb_mask;
  axi_data_t wr_word;
  axi_data_t rd_word;

  // Bits kept by each word kind, selected by index mod 4
  function automatic axi_data_t field_mask(input logic [1:0] kind);
    case (kind)
      2'd2:    field_mask = {{(DW-`RAB_ADDR_WIDTH_PHYS){1'b0}}, {`RAB_ADDR_WIDTH_PHYS{1'b1}}};
      2'd3:    field_mask = {{(DW-`RAB_N_FLAGS){1'b0}}, {`RAB_N_FLAGS{1'b1}}};
      default: field_mask = {{(DW-`RAB_ADDR_WIDTH_VIRT){1'b0}}, {`RAB_ADDR_WIDTH_VIRT{1'b1}}};
    endcase
  endfunction

  assign wr_idx = wr_addr_i[`RAB_WORD_LSB +: $bits(reg_idx_t)];
  assign rd_idx = rd_addr_i[`RAB_WORD_LSB +: $bits(reg_idx_t)];
  assign wr_hit = wr_en_i && (wr_addr_i < `RAB_L1_MAP_SIZE);

  always_comb
  begin
    for (int b = 0; b < DW/8; b++)
      strb_mask[b*8 +: 8] = {8{wr_strb_i[b]}};
  end

  // Unstrobed bytes keep their value, bytes outside the field end up zero
  assign wr_word = ((wr_data_i & strb_mask) | (l1_cfg_o[wr_idx] & ~strb_mask))
                   & field_mask(wr_idx[1:0]);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      l1_cfg_o <= '0; // All slices disabled
    else if (wr_hit)
      l1_cfg_o[wr_idx] <= wr_word;
  end

  // Address bit 2 returns the upper half for 32-bit hosts
  assign rd_word   = l1_cfg_o[rd_idx];
  assign rd_data_o = rd_addr_i[`RAB_WORD_LSB-1] ? {{(DW/2){1'b0}}, rd_word[DW-1:DW/2]}
                                                : rd_word;

endmodule

/* design/miss_fifo.sv */
/*
 Synchronous FIFO holding one field of the miss records.
 Push while full and pop while empty are ignored; the head is shown combinationally.
*/
`timescale 1ns/1ns
`include "rab_cfg_params.svh"

module miss_fifo #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  input  logic                  push_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  pop_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  empty_o,
  output logic                  full_o
);
  localparam int unsigned DEPTH = `RAB_MISS_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [DATA_WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [PTR_W:0]        count_q;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at DEPTH
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));

endmodule

/* design/miss_handler.sv */
/*
 Miss handler with one FIFO for miss addresses and one for miss IDs.
 Hardware misses win over software pushes; software drains both FIFOs by reads.
*/
`timescale 1ns/1ns
`include "rab_cfg_params.svh"

module miss_handler (
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  input  logic                    miss_i,
  input  rab_cfg_pkg::virt_addr_t miss_addr_i,
  input  rab_cfg_pkg::miss_id_t   miss_id_i,
  input  logic                    wr_en_i,
  input  rab_cfg_pkg::axi_addr_t  wr_addr_i,
  input  rab_cfg_pkg::axi_data_t  wr_data_i,
  input  rab_cfg_pkg::axi_addr_t  rd_addr_i,
  input  logic                    rd_done_i,
  output rab_cfg_pkg::axi_data_t  rd_data_o,
  output logic                    fifo_full_o
);
  import rab_cfg_pkg::*;

  logic [`RAB_FIFO_OFFS_WIDTH-1:0] wr_offs;
  logic [`RAB_FIFO_OFFS_WIDTH-1:0] rd_offs;
  logic       sw_wr;
  logic       addr_push;
  logic       addr_pop;
  logic       addr_empty;
  logic       addr_full;
  virt_addr_t addr_din;
  virt_addr_t addr_head;
  logic       id_push;
  logic       id_pop;
  logic       id_empty;
  logic       id_full;
  miss_id_t   id_din;
  miss_id_t   id_head;

  assign wr_offs = wr_addr_i[`RAB_FIFO_OFFS_WIDTH-1:0];
  assign rd_offs = rd_addr_i[`RAB_FIFO_OFFS_WIDTH-1:0];
  assign sw_wr   = wr_en_i && (wr_addr_i < `RAB_L1_MAP_SIZE);

  // Hardware miss goes to both FIFOs, a software push in that cycle is lost
  assign addr_push = miss_i | (sw_wr && (wr_offs == `RAB_FIFO_ADDR_OFFS));
  assign id_push   = miss_i | (sw_wr && (wr_offs == `RAB_FIFO_ID_OFFS));
  assign addr_din  = miss_i ? miss_addr_i : wr_data_i[$bits(virt_addr_t)-1:0];
  assign id_din    = miss_i ? miss_id_i : wr_data_i[$bits(miss_id_t)-1:0];

  assign addr_pop = rd_done_i && (rd_offs == `RAB_FIFO_ADDR_OFFS); // Ignored when empty
  assign id_pop   = rd_done_i && (rd_offs == `RAB_FIFO_ID_OFFS);

  assign fifo_full_o = (addr_push & addr_full) | (id_push & id_full);

  // Empty flag in the top bit, head entry in the low bits
  always_comb
  begin
    rd_data_o = '0;
    if (rd_offs == `RAB_FIFO_ID_OFFS)
    begin
      rd_data_o[$bits(miss_id_t)-1:0] = id_head;
      rd_data_o[$bits(axi_data_t)-1]  = id_empty;
    end
    else
    begin
      rd_data_o[$bits(virt_addr_t)-1:0] = addr_head;
      rd_data_o[$bits(axi_data_t)-1]    = addr_empty;
    end
  end

  miss_fifo #(.DATA_WIDTH($bits(virt_addr_t))) u_addr_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .pop_i   (addr_pop),
    .data_o  (addr_head),
    .empty_o (addr_empty),
    .full_o  (addr_full)
  );

  miss_fifo #(.DATA_WIDTH($bits(miss_id_t))) u_id_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (id_push),
    .data_i  (id_din),
    .pop_i   (id_pop),
    .data_o  (id_head),
    .empty_o (id_empty),
    .full_o  (id_full)
  );

endmodule

/* design/rab_cfg_top.sv */
/*
 Configuration port of the remapping address block.
 Joins the AXI4-Lite slave, the L1 slice bank and the miss handler,
 and selects FIFO read data for the two FIFO offsets.
*/
`timescale 1ns/1ns
`include "rab_cfg_params.svh"

module rab_cfg_top (
  input  logic                                     Clk_CI,
  input  logic                                     Rst_RBI,

  input  rab_cfg_pkg::axi_addr_t                   s_axi_awaddr_i,
  input  logic                                     s_axi_awvalid_i,
  output logic                                     s_axi_awready_o,
  input  rab_cfg_pkg::axi_data_t                   s_axi_wdata_i,
  input  rab_cfg_pkg::axi_strb_t                   s_axi_wstrb_i,
  input  logic                                     s_axi_wvalid_i,
  output logic                                     s_axi_wready_o,
  output logic [1:0]                               s_axi_bresp_o,
  output logic                                     s_axi_bvalid_o,
  input  logic                                     s_axi_bready_i,
  input  rab_cfg_pkg::axi_addr_t                   s_axi_araddr_i,
  input  logic                                     s_axi_arvalid_i,
  output logic                                     s_axi_arready_o,
  output rab_cfg_pkg::axi_data_t                   s_axi_rdata_o,
  output logic [1:0]                               s_axi_rresp_o,
  output logic                                     s_axi_rvalid_o,
  input  logic                                     s_axi_rready_i,

  output rab_cfg_pkg::axi_data_t [`RAB_N_REGS-1:0] L1Cfg_o,

  input  rab_cfg_pkg::virt_addr_t                  MissAddr_i,
  input  rab_cfg_pkg::miss_id_t                    MissId_i,
  input  logic                                     Miss_i,
  output logic                                     MhFifoFull_o
);
  import rab_cfg_pkg::*;

  logic      wr_en;
  axi_addr_t wr_addr;
  axi_data_t wr_data;
  axi_strb_t wr_strb;
  logic      rd_active;
  axi_addr_t rd_addr;
  logic      rd_done;
  axi_data_t rd_data;
  axi_data_t reg_rd_data;
  axi_data_t fifo_rd_data;
  logic      fifo_sel;
  logic [`RAB_FIFO_OFFS_WIDTH-1:0] rd_offs;

  assign rd_offs  = rd_addr[`RAB_FIFO_OFFS_WIDTH-1:0];
  assign fifo_sel = rd_active && ((rd_offs == `RAB_FIFO_ADDR_OFFS) ||
                                  (rd_offs == `RAB_FIFO_ID_OFFS));
  assign rd_data  = fifo_sel ? fifo_rd_data : reg_rd_data;

  axi_lite_slave u_slave (
    .Clk_CI          (Clk_CI),
    .Rst_RBI         (Rst_RBI),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .wr_en_o         (wr_en),
    .wr_addr_o       (wr_addr),
    .wr_data_o       (wr_data),
    .wr_strb_o       (wr_strb),
    .rd_active_o     (rd_active),
    .rd_addr_o       (rd_addr),
    .rd_done_o       (rd_done),
    .rd_data_i       (rd_data)
  );

  l1_cfg_regs u_regs (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_addr_i (rd_addr),
    .rd_data_o (reg_rd_data),
    .l1_cfg_o  (L1Cfg_o)
  );

  miss_handler u_miss (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .miss_i      (Miss_i),
    .miss_addr_i (MissAddr_i),
    .miss_id_i   (MissId_i),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .rd_addr_i   (rd_addr),
    .rd_done_i   (rd_done),
    .rd_data_o   (fifo_rd_data),
    .fifo_full_o (MhFifoFull_o)
  );

endmodule

/* tb/clk_rst_gen.sv */
/*
 Clock and reset source for the testbench.
 Free-running clock; reset is low for the first rising edges and released on a falling edge.
*/
`timescale 1ns/1ns

module clk_rst_gen #(
  parameter int unsigned PERIOD     = 100,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic Clk_CO,
  output logic Rst_RBO
);

  initial
  begin
    Clk_CO = 1'b0;
    forever #(PERIOD/2) Clk_CO = ~Clk_CO;
  end

  initial
  begin
    Rst_RBO = 1'b0;
    repeat (RST_CYCLES) @(posedge Clk_CO);
    @(negedge Clk_CO); // Release away from the active edge
    Rst_RBO = 1'b1;
  end

endmodule

/* tb/tb_rab_cfg.sv */
/*
 Testbench for the RAB configuration port.
 Builds a table of AXI writes, reads, L1 checks and miss pulses with expected values
 from a register and FIFO model, then applies it on falling clock edges.
*/
`timescale 1ns/1ns
`include "rab_cfg_params.svh"

module tb_rab_cfg;
  import rab_cfg_pkg::*;

  localparam int WAIT_LIMIT = 40; // Cycles per handshake
  localparam int DEPTH = `RAB_MISS_FIFO_DEPTH;
  localparam logic [63:0] ALL_BITS  = '1;
  localparam logic [63:0] EMPTY_BIT = 64'h8000_0000_0000_0000;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CFG, OP_MISS} op_e;

  logic Clk_C;
  logic Rst_RB;
  axi_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wvalid;
  logic      wready;
  logic [1:0] bresp;
  logic      bvalid;
  logic      bready;
  axi_addr_t araddr;
  logic      arvalid;
  logic      arready;
  axi_data_t rdata;
  logic [1:0] rresp;
  logic      rvalid;
  logic      rready;
  axi_data_t [`RAB_N_REGS-1:0] l1_cfg;
  virt_addr_t miss_addr;
  miss_id_t  miss_id;
  logic      miss;
  logic      fifo_full;

  // Stimulus table with one entry per index
  op_e         tbl_op[$];
  logic [31:0] tbl_addr[$];
  logic [63:0] tbl_data[$];
  logic [7:0]  tbl_strb[$];
  logic [63:0] tbl_exp[$];
  logic [63:0] tbl_mask[$];

  // Reference model state
  logic [63:0] reg_model [`RAB_N_REGS];
  logic [31:0] addr_fifo_model[$];
  logic [9:0]  id_fifo_model[$];
  logic [31:0] lcg_state;
  logic [63:0] rdata_got;

  clk_rst_gen #(.PERIOD(100), .RST_CYCLES(2)) u_clk_rst (
    .Clk_CO  (Clk_C),
    .Rst_RBO (Rst_RB)
  );

  rab_cfg_top DUT (
    .Clk_CI          (Clk_C),
    .Rst_RBI         (Rst_RB),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (wstrb),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .L1Cfg_o         (l1_cfg),
    .MissAddr_i      (miss_addr),
    .MissId_i        (miss_id),
    .Miss_i          (miss),
    .MhFifoFull_o    (fifo_full)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] random_word();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  // Bits kept by each word of a slice
  function automatic int field_bits(input int idx);
    case (idx % 4)
      2:       return `RAB_ADDR_WIDTH_PHYS;
      3:       return `RAB_N_FLAGS;
      default: return `RAB_ADDR_WIDTH_VIRT;
    endcase
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic wait_failed(input string what);
    $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic push_entry(input op_e op, input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb, input logic [63:0] exp,
                            input logic [63:0] mask);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_strb.push_back(strb);
    tbl_exp.push_back(exp);
    tbl_mask.push_back(mask);
  endtask

  task automatic add_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    int idx;
    int keep;
    logic [63:0] new_word;
    idx  = int'(addr[6:3]);
    keep = field_bits(idx);
    if (addr < `RAB_L1_MAP_SIZE)
    begin
      for (int i = 0; i < 64; i++)
        new_word[i] = (i >= keep) ? 1'b0 : (strb[i/8] ? data[i] : reg_model[idx][i]);
      reg_model[idx] = new_word;
      if (addr[5:0] == 6'd0 && addr_fifo_model.size() < DEPTH)
        addr_fifo_model.push_back(data[31:0]);
      if (addr[5:0] == 6'd8 && id_fifo_model.size() < DEPTH)
        id_fifo_model.push_back(data[9:0]);
    end
    push_entry(OP_WRITE, addr, data, strb, 64'd0, 64'd0);
  endtask

  task automatic add_read(input logic [31:0] addr);
    int idx;
    logic [63:0] exp;
    logic [63:0] mask;
    idx  = int'(addr[6:3]);
    exp  = EMPTY_BIT; // Only the flag is known on an empty FIFO
    mask = EMPTY_BIT;
    if (addr[5:0] == 6'd0)
    begin
      if (addr_fifo_model.size() > 0)
      begin
        exp  = {32'd0, addr_fifo_model.pop_front()};
        mask = ALL_BITS;
      end
    end
    else if (addr[5:0] == 6'd8)
    begin
      if (id_fifo_model.size() > 0)
      begin
        exp  = {54'd0, id_fifo_model.pop_front()};
        mask = ALL_BITS;
      end
    end
    else
    begin
      exp  = addr[2] ? {32'd0, reg_model[idx][63:32]} : reg_model[idx];
      mask = ALL_BITS;
    end
    push_entry(OP_READ, addr, 64'd0, 8'd0, exp, mask);
  endtask

  task automatic add_cfg(input int idx);
    push_entry(OP_CFG, idx, 64'd0, 8'd0, reg_model[idx], ALL_BITS);
  endtask

  // Hardware miss pushes both FIFOs and a full one drops the entry
  task automatic add_miss(input logic [31:0] addr, input logic [9:0] id);
    logic full;
    full = (addr_fifo_model.size() == DEPTH) || (id_fifo_model.size() == DEPTH);
    if (addr_fifo_model.size() < DEPTH)
      addr_fifo_model.push_back(addr);
    if (id_fifo_model.size() < DEPTH)
      id_fifo_model.push_back(id);
    push_entry(OP_MISS, addr, {54'd0, id}, 8'd0, {63'd0, full}, ALL_BITS);
  endtask

  task automatic build_table();
    logic [31:0] r;
    // Virtual words away from the FIFO offsets
    add_write(32'h20, random_word(), 8'hFF);
    add_read(32'h20);
    add_cfg(4);
    add_write(32'h68, random_word(), 8'hFF);
    add_read(32'h68);
    add_cfg(13);
    // Partial strobes
    add_write(32'h20, random_word(), 8'h05);
    add_read(32'h20);
    add_write(32'h20, random_word(), 8'hF0);
    add_read(32'h20);
    add_write(32'h28, random_word(), 8'h3C);
    add_read(32'h28);
    // Physical and flags words with upper half reads
    add_write(32'h30, random_word(), 8'hFF);
    add_read(32'h30);
    add_read(32'h34);
    add_write(32'h70, random_word(), 8'h31);
    add_read(32'h74);
    add_write(32'h38, random_word(), 8'hFF);
    add_read(32'h38);
    add_read(32'h3C);
    add_cfg(7);
    // Outside the L1 window
    add_write(32'h4020, random_word(), 8'hFF);
    add_cfg(4);
    add_write(32'h8030, random_word(), 8'hFF);
    add_cfg(6);
    // Miss FIFOs with hardware then software pushes
    add_read(32'h00);
    add_read(32'h08);
    for (int i = 0; i < 3; i++)
    begin
      r = lcg_next();
      add_miss(lcg_next(), r[9:0]);
    end
    add_write(32'h00, random_word(), 8'hFF);
    add_write(32'h08, random_word(), 8'hFF);
    for (int i = 0; i < 5; i++)
      add_read(32'h00);
    for (int i = 0; i < 5; i++)
      add_read(32'h08);
    // Overflow on the seventeenth miss
    for (int i = 0; i <= DEPTH; i++)
    begin
      r = lcg_next();
      add_miss(lcg_next(), r[9:0]);
    end
    for (int i = 0; i <= DEPTH; i++)
      add_read(32'h00);
    for (int i = 0; i <= DEPTH; i++)
      add_read(32'h08);
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    int n;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    n = 0;
    while (!(awready && wready))
    begin
      @(negedge Clk_C);
      n++;
      if (n > WAIT_LIMIT)
        wait_failed("AW and W ready");
    end
    @(negedge Clk_C); // AW and W taken on the edge in between
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid)
    begin
      @(negedge Clk_C);
      n++;
      if (n > WAIT_LIMIT)
        wait_failed("write response");
    end
    check_value(64'(bresp), 64'd0, "write response code");
    @(negedge Clk_C);
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [63:0] data);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready)
    begin
      @(negedge Clk_C);
      n++;
      if (n > WAIT_LIMIT)
        wait_failed("AR ready");
    end
    @(negedge Clk_C);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid)
    begin
      @(negedge Clk_C);
      n++;
      if (n > WAIT_LIMIT)
        wait_failed("read data");
    end
    data = rdata;
    check_value(64'(rresp), 64'd0, "read response code");
    @(negedge Clk_C); // R handshake pops the FIFO here
  endtask

  task automatic pulse_miss(input logic [31:0] addr, input logic [9:0] id,
                            input logic exp_full);
    miss      = 1'b1;
    miss_addr = addr;
    miss_id   = id;
    #25; // Flag settled by mid low phase
    check_value(64'(fifo_full), 64'(exp_full), "miss FIFO full flag");
    @(negedge Clk_C);
    miss = 1'b0;
  endtask

  initial
  begin
    int n;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    miss_addr = '0;
    miss_id   = '0;
    miss      = 1'b0;
    lcg_state = 32'd10062;
    for (int i = 0; i < `RAB_N_REGS; i++)
      reg_model[i] = 64'd0;
    build_table();

    n = 0;
    while (Rst_RB !== 1'b1)
    begin
      @(negedge Clk_C);
      n++;
      if (n > WAIT_LIMIT)
        wait_failed("reset release");
    end
    @(negedge Clk_C);

    for (int i = 0; i < tbl_op.size(); i++)
    begin
      case (tbl_op[i])
        OP_WRITE: axi_write(tbl_addr[i], tbl_data[i], tbl_strb[i]);
        OP_READ:
        begin
          axi_read(tbl_addr[i], rdata_got);
          check_value(rdata_got & tbl_mask[i], tbl_exp[i] & tbl_mask[i],
                      $sformatf("entry %0d read of 0x%08h", i, tbl_addr[i]));
        end
        OP_CFG:
          check_value(l1_cfg[tbl_addr[i][3:0]], tbl_exp[i],
                      $sformatf("entry %0d L1 word %0d", i, tbl_addr[i]));
        default: pulse_miss(tbl_addr[i], tbl_data[i][9:0], tbl_exp[i][0]);
      endcase
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* rab_cfg.f */
+incdir+design
design/rab_cfg_pkg.sv
design/axi_lite_slave.sv
design/l1_cfg_regs.sv
design/miss_fifo.sv
design/miss_handler.sv
design/rab_cfg_top.sv
tb/clk_rst_gen.sv
tb/tb_rab_cfg.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the RAB configuration port testbench with Verilator and run it.
# Exit status is non-zero when the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_rab_cfg -f rab_cfg.f -o sim_tb_rab_cfg; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_rab_cfg > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation passed"
exit 0
